// ==== verilog/core_pkg.sv ====
package core_pkg;

    // Core sizing
    localparam int NUM_WARPS      = 4;
    localparam int WARP_ID_WIDTH  = 2;
    localparam int DATA_WIDTH     = 32;
    localparam int PC_WIDTH       = 8;
    localparam int REG_ADDR_WIDTH = 3;
    localparam int NUM_REGS       = 1 << REG_ADDR_WIDTH;
    localparam int INSTR_WIDTH    = 32;

    // Instruction field positions
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 28;
    localparam int RD_MSB     = 27;
    localparam int RD_LSB     = 25;
    localparam int RS1_MSB    = 24;
    localparam int RS1_LSB    = 22;
    localparam int RS2_MSB    = 21;
    localparam int RS2_LSB    = 19;
    localparam int IMM_MSB    = 15;
    localparam int IMM_LSB    = 0;
    localparam int IMM_WIDTH  = IMM_MSB - IMM_LSB + 1;

    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_OR    = 4'h3,
        OP_XOR   = 4'h4,
        OP_SLT   = 4'h5,
        OP_ADDI  = 4'h6,
        OP_WID   = 4'h7,
        OP_BEQ   = 4'h8,
        OP_STORE = 4'h9,
        OP_SYNC  = 4'ha,
        OP_HALT  = 4'hb
    } opcode_t;

    typedef enum logic [2:0] {
        WARP_IDLE,
        WARP_READY,
        WARP_FETCH,
        WARP_EXECUTE,
        WARP_SYNC_WAIT,
        WARP_DONE
    } warp_state_t;

endpackage

// ==== verilog/warp_scheduler.sv ====
`timescale 1ns/10ps

module warp_scheduler import core_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic [PC_WIDTH-1:0]      base_address,
    input  logic [WARP_ID_WIDTH:0]   num_warps,
    input  logic                     fetch_done,
    input  opcode_t                  op,
    input  logic [PC_WIDTH-1:0]      next_pc,
    output logic [WARP_ID_WIDTH-1:0] current_warp,
    output logic [PC_WIDTH-1:0]      current_pc,
    output logic                     fetch_start,
    output logic                     execute,
    output logic                     done
);

    warp_state_t              warp_state [NUM_WARPS];
    logic [PC_WIDTH-1:0]      pc [NUM_WARPS];
    logic [WARP_ID_WIDTH-1:0] last_warp;
    logic [WARP_ID_WIDTH-1:0] pick_warp;
    logic                     pick_found;
    logic                     running;
    logic                     launch;
    logic [NUM_WARPS-1:0]     busy_vec;
    logic [NUM_WARPS-1:0]     sync_vec;
    logic [NUM_WARPS-1:0]     parked_vec;
    logic [NUM_WARPS-1:0]     finished_vec;
    logic                     sync_release;
    logic                     all_finished;

    assign launch = start && !running;

    // Per-warp status summaries
    always_comb begin
        for (int i = 0; i < NUM_WARPS; i++) begin
            busy_vec[i]     = (warp_state[i] == WARP_FETCH) || (warp_state[i] == WARP_EXECUTE);
            sync_vec[i]     = (warp_state[i] == WARP_SYNC_WAIT);
            finished_vec[i] = (warp_state[i] == WARP_IDLE) || (warp_state[i] == WARP_DONE);
            parked_vec[i]   = finished_vec[i] || sync_vec[i];
        end
    end

    // Barrier opens once nobody is left running toward it
    assign sync_release = (|sync_vec) && (&parked_vec);
    assign all_finished = &finished_vec;

    // Round-robin search, starting after the last warp chosen
    always_comb begin
        logic [WARP_ID_WIDTH-1:0] idx;
        pick_found = 1'b0;
        pick_warp  = last_warp;
        for (int k = 1; k <= NUM_WARPS; k++) begin
            idx = last_warp + WARP_ID_WIDTH'(k);
            if (!pick_found && warp_state[idx] == WARP_READY) begin
                pick_found = 1'b1;
                pick_warp  = idx;
            end
        end
    end

    // Only one instruction in flight on the shared port
    assign fetch_start  = pick_found && (busy_vec == '0);
    assign current_warp = fetch_start ? pick_warp : last_warp;
    assign current_pc   = pc[current_warp];
    assign execute      = (warp_state[last_warp] == WARP_EXECUTE);

    always_ff @(posedge clk) begin
        if (reset) begin
            running   <= 1'b0;
            done      <= 1'b0;
            last_warp <= '0;
            for (int i = 0; i < NUM_WARPS; i++) begin
                warp_state[i] <= WARP_IDLE;
            end
        end else if (launch) begin
            running <= 1'b1;
            done    <= 1'b0;
            for (int i = 0; i < NUM_WARPS; i++) begin
                warp_state[i] <= (i < int'(num_warps)) ? WARP_READY : WARP_IDLE;
            end
        end else if (running) begin
            if (fetch_start) begin
                warp_state[pick_warp] <= WARP_FETCH;
                last_warp             <= pick_warp;
            end
            if (fetch_done) begin
                warp_state[last_warp] <= WARP_EXECUTE;
            end
            if (execute) begin
                case (op)
                    OP_SYNC: warp_state[last_warp] <= WARP_SYNC_WAIT;
                    OP_HALT: warp_state[last_warp] <= WARP_DONE;
                    default: warp_state[last_warp] <= WARP_READY;
                endcase
            end
            if (sync_release) begin
                for (int i = 0; i < NUM_WARPS; i++) begin
                    if (sync_vec[i]) begin
                        warp_state[i] <= WARP_READY;
                    end
                end
            end
            if (all_finished) begin
                running <= 1'b0;
                done    <= 1'b1;
            end
        end
    end

    // Program counters
    always_ff @(posedge clk) begin
        if (launch) begin
            for (int i = 0; i < NUM_WARPS; i++) begin
                pc[i] <= base_address;
            end
        end else if (execute) begin
            pc[last_warp] <= next_pc;
        end
    end

    a_fetch_ready: assert property (@(posedge clk) disable iff (reset)
        fetch_start |=> warp_state[last_warp] == WARP_FETCH)
        else $error("warp %0d did not enter fetch after fetch_start", last_warp);

    a_single_busy: assert property (@(posedge clk) disable iff (reset)
        $onehot0(busy_vec))
        else $error("more than one warp in fetch or execute: %b", busy_vec);

endmodule

// ==== verilog/instr_fetch.sv ====
`timescale 1ns/10ps

module instr_fetch import core_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetch_start,
    input  logic [PC_WIDTH-1:0]    current_pc,
    input  logic                   instr_ready,
    input  logic [INSTR_WIDTH-1:0] instr_data,
    output logic                   instr_valid,
    output logic [PC_WIDTH-1:0]    instr_address,
    output logic                   fetch_done,
    output logic [INSTR_WIDTH-1:0] instruction
);

    // Request completes on the handshake cycle
    assign fetch_done = instr_valid && instr_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            instr_valid <= 1'b0;
        end else if (fetch_start) begin
            instr_valid <= 1'b1;
        end else if (fetch_done) begin
            instr_valid <= 1'b0;
        end
    end

    // Address held for the whole request
    always_ff @(posedge clk) begin
        if (fetch_start) begin
            instr_address <= current_pc;
        end
    end

    // Instruction register, read by the decoder during execute
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instruction <= instr_data;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        instr_valid && !instr_ready |=> instr_valid && $stable(instr_address))
        else $error("instr_address changed while request was pending");

endmodule

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder import core_pkg::*; (
    input  logic [INSTR_WIDTH-1:0]    instruction,
    output opcode_t                   op,
    output logic [REG_ADDR_WIDTH-1:0] rd,
    output logic [REG_ADDR_WIDTH-1:0] rs1,
    output logic [REG_ADDR_WIDTH-1:0] rs2,
    output logic [DATA_WIDTH-1:0]     immediate,
    output logic                      reg_write
);

    logic writes_rd;

    assign op  = opcode_t'(instruction[OPCODE_MSB:OPCODE_LSB]);
    assign rd  = instruction[RD_MSB:RD_LSB];
    assign rs1 = instruction[RS1_MSB:RS1_LSB];
    assign rs2 = instruction[RS2_MSB:RS2_LSB];

    // Sign-extended immediate
    assign immediate = {{(DATA_WIDTH - IMM_WIDTH){instruction[IMM_MSB]}},
                        instruction[IMM_MSB:IMM_LSB]};

    // Operations that produce a register result
    always_comb begin
        case (op)
            OP_ADD,
            OP_SUB,
            OP_AND,
            OP_OR,
            OP_XOR,
            OP_SLT,
            OP_ADDI,
            OP_WID:  writes_rd = 1'b1;
            default: writes_rd = 1'b0;
        endcase
    end

    // Writes to register 0 are dropped here
    assign reg_write = writes_rd && (rd != '0);

endmodule

// ==== verilog/warp_reg_file.sv ====
`timescale 1ns/10ps

module warp_reg_file import core_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [WARP_ID_WIDTH-1:0]  current_warp,
    input  logic [REG_ADDR_WIDTH-1:0] rs1,
    input  logic [REG_ADDR_WIDTH-1:0] rs2,
    input  logic [REG_ADDR_WIDTH-1:0] rd,
    input  logic                      write_enable,
    input  logic [DATA_WIDTH-1:0]     write_data,
    output logic [DATA_WIDTH-1:0]     rs1_data,
    output logic [DATA_WIDTH-1:0]     rs2_data
);

    // One bank of scalar registers per warp
    logic [DATA_WIDTH-1:0] regs [NUM_WARPS][NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                for (int r = 0; r < NUM_REGS; r++) begin
                    regs[w][r] <= '0;
                end
            end
        end else if (write_enable) begin
            regs[current_warp][rd] <= write_data;
        end
    end

    // Register 0 is never written, so it reads zero
    assign rs1_data = regs[current_warp][rs1];
    assign rs2_data = regs[current_warp][rs2];

    a_no_r0_write: assert property (@(posedge clk) disable iff (reset)
        write_enable |-> rd != '0)
        else $error("write to register 0 in warp %0d", current_warp);

endmodule

// ==== verilog/int_execute.sv ====
`timescale 1ns/10ps

module int_execute import core_pkg::*; (
    input  logic                     execute,
    input  opcode_t                  op,
    input  logic [DATA_WIDTH-1:0]    immediate,
    input  logic                     reg_write,
    input  logic [DATA_WIDTH-1:0]    rs1_data,
    input  logic [DATA_WIDTH-1:0]    rs2_data,
    input  logic [PC_WIDTH-1:0]      current_pc,
    input  logic [WARP_ID_WIDTH-1:0] current_warp,
    output logic [DATA_WIDTH-1:0]    result,
    output logic                     reg_write_enable,
    output logic [PC_WIDTH-1:0]      next_pc,
    output logic                     store_strobe,
    output logic [DATA_WIDTH-1:0]    store_address,
    output logic [DATA_WIDTH-1:0]    store_data
);

    logic branch_taken;

    // Integer ALU
    always_comb begin
        case (op)
            OP_ADD:  result = rs1_data + rs2_data;
            OP_SUB:  result = rs1_data - rs2_data;
            OP_AND:  result = rs1_data & rs2_data;
            OP_OR:   result = rs1_data | rs2_data;
            OP_XOR:  result = rs1_data ^ rs2_data;
            OP_SLT:  result = DATA_WIDTH'($signed(rs1_data) < $signed(rs2_data));
            OP_ADDI: result = rs1_data + immediate;
            OP_WID:  result = DATA_WIDTH'(current_warp);
            default: result = '0;
        endcase
    end

    // Branch offset is relative to the branch itself
    assign branch_taken = (op == OP_BEQ) && (rs1_data == rs2_data);
    assign next_pc      = branch_taken ? current_pc + immediate[PC_WIDTH-1:0]
                                       : current_pc + PC_WIDTH'(1);

    assign reg_write_enable = execute && reg_write;

    // Store port, one strobe per executed store
    assign store_strobe  = execute && (op == OP_STORE);
    assign store_address = rs1_data + immediate;
    assign store_data    = rs2_data;

endmodule

// ==== verilog/compute_core.sv ====
`timescale 1ns/10ps

module compute_core import core_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic [PC_WIDTH-1:0]    base_address,
    input  logic [WARP_ID_WIDTH:0] num_warps,
    output logic                   done,
    output logic                   instr_valid,
    output logic [PC_WIDTH-1:0]    instr_address,
    input  logic                   instr_ready,
    input  logic [INSTR_WIDTH-1:0] instr_data,
    output logic                   store_strobe,
    output logic [DATA_WIDTH-1:0]  store_address,
    output logic [DATA_WIDTH-1:0]  store_data
);

    logic [WARP_ID_WIDTH-1:0]  current_warp;
    logic [PC_WIDTH-1:0]       current_pc;
    logic [PC_WIDTH-1:0]       next_pc;
    logic                      fetch_start;
    logic                      fetch_done;
    logic                      execute;
    logic [INSTR_WIDTH-1:0]    instruction;
    opcode_t                   op;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic [REG_ADDR_WIDTH-1:0] rs2;
    logic [DATA_WIDTH-1:0]     immediate;
    logic                      reg_write;
    logic                      reg_write_enable;
    logic [DATA_WIDTH-1:0]     rs1_data;
    logic [DATA_WIDTH-1:0]     rs2_data;
    logic [DATA_WIDTH-1:0]     result;

    warp_scheduler scheduler (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .base_address (base_address),
        .num_warps    (num_warps),
        .fetch_done   (fetch_done),
        .op           (op),
        .next_pc      (next_pc),
        .current_warp (current_warp),
        .current_pc   (current_pc),
        .fetch_start  (fetch_start),
        .execute      (execute),
        .done         (done)
    );

    instr_fetch fetcher (
        .clk           (clk),
        .reset         (reset),
        .fetch_start   (fetch_start),
        .current_pc    (current_pc),
        .instr_ready   (instr_ready),
        .instr_data    (instr_data),
        .instr_valid   (instr_valid),
        .instr_address (instr_address),
        .fetch_done    (fetch_done),
        .instruction   (instruction)
    );

    instr_decoder decoder (
        .instruction (instruction),
        .op          (op),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .immediate   (immediate),
        .reg_write   (reg_write)
    );

    warp_reg_file reg_file (
        .clk          (clk),
        .reset        (reset),
        .current_warp (current_warp),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .write_enable (reg_write_enable),
        .write_data   (result),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    int_execute alu (
        .execute          (execute),
        .op               (op),
        .immediate        (immediate),
        .reg_write        (reg_write),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .current_pc       (current_pc),
        .current_warp     (current_warp),
        .result           (result),
        .reg_write_enable (reg_write_enable),
        .next_pc          (next_pc),
        .store_strobe     (store_strobe),
        .store_address    (store_address),
        .store_data       (store_data)
    );

endmodule

// ==== bench/instr_mem_model.sv ====
`timescale 1ns/10ps

module instr_mem_model import core_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  logic [PC_WIDTH-1:0]    instr_address,
    output logic                   instr_ready,
    output logic [INSTR_WIDTH-1:0] instr_data
);

    logic [INSTR_WIDTH-1:0] mem [1 << PC_WIDTH];
    int                     delay;
    bit                     waiting;

    function automatic logic [INSTR_WIDTH-1:0] encode(opcode_t op, int rd, int rs1, int rs2,
                                                      int imm);
        return {op, rd[2:0], rs1[2:0], rs2[2:0], 3'b000, imm[15:0]};
    endfunction

    initial begin
        instr_ready = 1'b0;
        instr_data  = '0;
        delay       = 0;
        waiting     = 1'b0;
        // Unused words halt, tagged with their own address
        for (int a = 0; a < (1 << PC_WIDTH); a++) begin
            mem[a] = {OP_HALT, 12'h000, 8'(a), 8'(a ^ 8'h5a)};
        end
        // Arithmetic kernel at 0x00, one store per warp at 16 + warp
        mem[8'h00] = encode(OP_WID, 1, 0, 0, 0);
        mem[8'h01] = encode(OP_ADDI, 2, 0, 0, 13);
        mem[8'h02] = encode(OP_ADD, 3, 1, 2, 0);
        mem[8'h03] = encode(OP_SUB, 4, 1, 2, 0);
        mem[8'h04] = encode(OP_AND, 5, 3, 4, 0);
        mem[8'h05] = encode(OP_OR, 6, 3, 4, 0);
        mem[8'h06] = encode(OP_XOR, 7, 5, 6, 0);
        mem[8'h07] = encode(OP_SLT, 5, 4, 1, 0);
        mem[8'h08] = encode(OP_ADD, 7, 7, 5, 0);
        mem[8'h09] = encode(OP_STORE, 0, 1, 7, 16);
        mem[8'h0a] = encode(OP_HALT, 0, 0, 0, 0);
        // Counting loop at 0x20, stores the count at 64 + warp
        mem[8'h20] = encode(OP_ADDI, 2, 0, 0, 5);
        mem[8'h21] = encode(OP_ADDI, 1, 0, 0, 0);
        mem[8'h22] = encode(OP_ADDI, 1, 1, 0, 1);
        mem[8'h23] = encode(OP_BEQ, 0, 1, 2, 2);
        mem[8'h24] = encode(OP_BEQ, 0, 0, 0, -2);
        mem[8'h25] = encode(OP_WID, 3, 0, 0, 0);
        mem[8'h26] = encode(OP_STORE, 0, 3, 1, 64);
        mem[8'h27] = encode(OP_HALT, 0, 0, 0, 0);
        // Barrier kernel at 0x40, phase A at 0x80 + warp, phase B at 0x90 + warp
        // Warp w spins w times first, so the warps reach the barrier apart
        mem[8'h40] = encode(OP_WID, 1, 0, 0, 0);
        mem[8'h41] = encode(OP_ADDI, 3, 0, 0, 0);
        mem[8'h42] = encode(OP_BEQ, 0, 3, 1, 3);
        mem[8'h43] = encode(OP_ADDI, 3, 3, 0, 1);
        mem[8'h44] = encode(OP_BEQ, 0, 0, 0, -2);
        mem[8'h45] = encode(OP_ADDI, 2, 0, 0, 32'h0a);
        mem[8'h46] = encode(OP_STORE, 0, 1, 2, 32'h80);
        mem[8'h47] = encode(OP_SYNC, 0, 0, 0, 0);
        mem[8'h48] = encode(OP_ADDI, 2, 0, 0, 32'h0b);
        mem[8'h49] = encode(OP_STORE, 0, 1, 2, 32'h90);
        mem[8'h4a] = encode(OP_HALT, 0, 0, 0, 0);
    end

    // Answers each request after 0 to 3 cycles
    always @(negedge clk) begin
        if (reset) begin
            instr_ready <= 1'b0;
            waiting = 1'b0;
        end else if (instr_ready) begin
            instr_ready <= 1'b0;
        end else if (instr_valid) begin
            if (!waiting) begin
                delay = int'($urandom % 4);
                waiting = 1'b1;
            end
            if (delay == 0) begin
                instr_ready <= 1'b1;
                instr_data  <= mem[instr_address];
                waiting = 1'b0;
            end else begin
                delay--;
            end
        end
    end

endmodule

// ==== bench/compute_core_tb.sv ====
`timescale 1ns/10ps

module compute_core_tb import core_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam logic [PC_WIDTH-1:0] ARITH_BASE = 8'h00;
    localparam logic [PC_WIDTH-1:0] LOOP_BASE  = 8'h20;
    localparam logic [PC_WIDTH-1:0] SYNC_BASE  = 8'h40;
    localparam int LOOP_LIMIT = 5;
    // Most instructions any one warp executes in each kernel
    localparam int ARITH_LEN = 11;
    localparam int LOOP_LEN  = 19;
    localparam int SYNC_LEN  = 18;
    localparam int WATCHDOG_CYCLES = 8 * (ARITH_LEN * 4 + LOOP_LEN * 4 + SYNC_LEN * 4
                                          + ARITH_LEN * 2 + SYNC_LEN * 3 + LOOP_LEN * 4) + 500;

    logic                   clk;
    logic                   reset;
    logic                   start;
    logic [PC_WIDTH-1:0]    base_address;
    logic [WARP_ID_WIDTH:0] num_warps;
    logic                   done;
    logic                   instr_valid;
    logic [PC_WIDTH-1:0]    instr_address;
    logic                   instr_ready;
    logic [INSTR_WIDTH-1:0] instr_data;
    logic                   store_strobe;
    logic [DATA_WIDTH-1:0]  store_address;
    logic [DATA_WIDTH-1:0]  store_data;

    int                    store_hits [int];
    logic [DATA_WIDTH-1:0] store_vals [int];
    int phase_a_count;
    int active_warps;
    int fail_count;
    int test_count;
    int test_fail_base;

    compute_core UUT (.*);

    instr_mem_model instr_mem (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Store port monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && store_strobe) begin
            store_hits[int'(store_address)] = store_hits[int'(store_address)] + 1;
            store_vals[int'(store_address)] = store_data;
            if (store_address >= 32'h80 && store_address < 32'h84) begin
                phase_a_count++;
            end
        end
    end

    a_barrier_order: assert property (@(posedge clk) disable iff (reset)
        store_strobe && store_address >= 32'h90 && store_address < 32'h94
        |-> phase_a_count == active_warps)
        else begin
            $display("Barrier broken at %0t: phase-B store before all phase-A stores", $time);
            fail_count++;
        end

    a_quiet_after_done: assert property (@(posedge clk) disable iff (reset)
        done |-> !instr_valid)
        else begin
            $display("FAIL %0t instr_valid expected 0 actual 1 while done", $time);
            fail_count++;
        end

    a_addr_hold: assert property (@(posedge clk) disable iff (reset)
        instr_valid && !instr_ready |=> $stable(instr_address))
        else begin
            $display("instr_address moved while a request was waiting, at %0t", $time);
            fail_count++;
        end

    a_ready_in_request: assert property (@(posedge clk) disable iff (reset)
        instr_ready |-> instr_valid)
        else begin
            $display("Memory model raised instr_ready without a request at %0t", $time);
            fail_count++;
        end

    // Stored value of the arithmetic kernel, from the instruction rules
    function automatic logic [DATA_WIDTH-1:0] arith_expect(int w);
        logic [DATA_WIDTH-1:0] sum;
        logic [DATA_WIDTH-1:0] diff;
        sum  = DATA_WIDTH'(w) + 32'd13;
        diff = DATA_WIDTH'(w) - 32'd13;
        return ((sum & diff) ^ (sum | diff)) + 32'd1;
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic run_kernel(input logic [PC_WIDTH-1:0] base, input int warps);
        store_hits.delete();
        store_vals.delete();
        phase_a_count = 0;
        active_warps  = warps;
        @(negedge clk);
        start        = 1'b1;
        base_address = base;
        num_warps    = (WARP_ID_WIDTH + 1)'(warps);
        @(negedge clk);
        start = 1'b0;
        while (!done) @(negedge clk);
    endtask

    task automatic check_hits(input int addr, input int expected);
        int actual;
        actual = store_hits.exists(addr) ? store_hits[addr] : 0;
        assert (actual == expected) else begin
            $display("FAIL %0t store_hits[0x%0h] expected %0d actual %0d",
                     $time, addr, expected, actual);
            fail_count++;
        end
    endtask

    task automatic check_store(input int addr, input logic [DATA_WIDTH-1:0] expected);
        logic [DATA_WIDTH-1:0] actual;
        check_hits(addr, 1);
        actual = store_vals.exists(addr) ? store_vals[addr] : 'x;
        assert (actual === expected) else begin
            $display("FAIL %0t store_data[0x%0h] expected 0x%0h actual 0x%0h",
                     $time, addr, expected, actual);
            fail_count++;
        end
    endtask

    task automatic check_low(input string name, input logic actual);
        assert (actual === 1'b0) else begin
            $display("FAIL %0t %s expected 0 actual %b", $time, name, actual);
            fail_count++;
        end
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (fail_count == test_fail_base) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            $display("Test %0d %s: %0d errors", test_count, name, fail_count - test_fail_base);
        end
        test_fail_base = fail_count;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: the core never finished its kernels, it looks hung");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h0933_fde2));
        reset          = 1'b1;
        start          = 1'b0;
        base_address   = '0;
        num_warps      = '0;
        fail_count     = 0;
        test_count     = 0;
        test_fail_base = 0;
        phase_a_count  = 0;
        active_warps   = 0;
        apply_reset();

        run_kernel(ARITH_BASE, 4);
        for (int w = 0; w < 4; w++) check_store(16 + w, arith_expect(w));
        report_test("arithmetic per warp");

        run_kernel(LOOP_BASE, 4);
        for (int w = 0; w < 4; w++) check_store(64 + w, DATA_WIDTH'(LOOP_LIMIT));
        report_test("branch loop");

        run_kernel(SYNC_BASE, 4);
        for (int w = 0; w < 4; w++) begin
            check_store(32'h80 + w, 32'h0a);
            check_store(32'h90 + w, 32'h0b);
        end
        report_test("barrier");

        run_kernel(ARITH_BASE, 2);
        for (int w = 0; w < 2; w++) check_store(16 + w, arith_expect(w));
        check_hits(18, 0);
        check_hits(19, 0);
        report_test("partial warp count");

        run_kernel(SYNC_BASE, 3);
        for (int w = 0; w < 3; w++) check_store(32'h90 + w, 32'h0b);
        repeat (10) begin
            @(negedge clk);
            check_low("instr_valid", instr_valid);
        end
        report_test("instruction port after done");

        apply_reset();
        check_low("done", done);
        check_low("instr_valid", instr_valid);
        check_low("store_strobe", store_strobe);
        run_kernel(LOOP_BASE, 4);
        for (int w = 0; w < 4; w++) check_store(64 + w, DATA_WIDTH'(LOOP_LIMIT));
        report_test("reset and rerun");

        $display("Tests run: %0d, checks failed: %0d", test_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/core_pkg.sv
verilog/warp_scheduler.sv
verilog/instr_fetch.sv
verilog/instr_decoder.sv
verilog/warp_reg_file.sv
verilog/int_execute.sv
verilog/compute_core.sv
bench/instr_mem_model.sv
bench/compute_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the compute core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module compute_core_tb \
    -f vlog.f \
    -o compute_core_sim

# The log decides the result, so a nonzero exit here must not stop the script
./obj_dir/compute_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
